//--- design/mandel_pkg.sv
package mandel_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fixed-point number format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int DATA_W     = 12;               // Signed value width
    localparam int FRAC_W     = 8;                // Fraction bits, range -8 .. <8
    localparam int CTR_W      = 8;                // Iteration counter
    localparam int PROD_W     = 2 * DATA_W;       // Full product
    localparam int SQ_W       = PROD_W - FRAC_W;  // Product after fraction shift
    localparam int EXT_W      = SQ_W + 2;         // Guard bits for sums and doubling
    localparam int MUL_CNT_W  = $clog2(DATA_W);   // Multiplier step counter
    localparam int ESCAPE_LIM = 4 << FRAC_W;      // 4.0 in fixed point

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Image geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int IMG_W = 16;
    localparam int IMG_H = 12;
    localparam int X_W   = $clog2(IMG_W);
    localparam int Y_W   = $clog2(IMG_H);

    typedef logic signed [DATA_W-1:0] data_t;

    // Frame configuration, held stable while a frame runs
    typedef struct packed {
        logic [CTR_W-1:0] max_ctr;
        logic [1:0]       shade_sel;
        logic [6:0]       step;       // Increment is step + 1
        data_t            cr_offset;
        data_t            ci_offset;
    } mandel_cfg_t;

    typedef struct packed {
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
        logic [3:0]     shade;
    } mandel_pix_t;

    // One iteration step request and result
    typedef struct packed {
        data_t cr;
        data_t ci;
        data_t zr;
        data_t zi;
    } alu_req_t;

    typedef struct packed {
        data_t new_zr;
        data_t new_zi;
        logic  escaped;
        logic  overflow;
    } alu_rsp_t;

endpackage

//--- design/mandel_mult.sv
`timescale 1ns/1ps

module mandel_mult (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  mandel_pkg::data_t                     a,
    input  mandel_pkg::data_t                     b,
    output logic                                  done,
    output logic signed [mandel_pkg::PROD_W-1:0]  p
);
    import mandel_pkg::*;

    logic                      busy;
    logic [MUL_CNT_W-1:0]      cnt;      // Index of the multiplier bit in work
    logic signed [PROD_W-1:0]  mcand;    // a, shifted up one place per step
    logic [DATA_W-1:0]         mplier;   // b, shifted down one place per step
    logic signed [PROD_W-1:0]  pp;
    logic                      last;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Partial product
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        pp   = mplier[0] ? mcand : '0;
        last = (cnt == MUL_CNT_W'(DATA_W - 1));   // Sign bit of b, negative weight
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Step control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;      // Product visible DATA_W + 1 cycles after start
                end
            end
        end
    end

    // Accumulator and operand shifters
    always_ff @(posedge clk) begin
        if (start) begin
            p      <= '0;
            mcand  <= PROD_W'(a);      // Sign extended
            mplier <= b;
        end else if (busy) begin
            if (last) begin
                p <= p - pp;
            end else begin
                p <= p + pp;
            end
            mcand  <= mcand <<< 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

//--- design/mandel_alu.sv
`timescale 1ns/1ps

module mandel_alu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  mandel_pkg::alu_req_t  req,
    output logic                  done,
    output mandel_pkg::alu_rsp_t  rsp
);
    import mandel_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_RR, S_II, S_RI, S_FIN} state_t;

    state_t                    state;
    alu_req_t                  req_q;
    logic signed [SQ_W-1:0]    sq_rr;     // zr * zr after fraction shift
    logic signed [SQ_W-1:0]    sq_ii;     // zi * zi
    logic signed [SQ_W-1:0]    x_ri;      // zr * zi
    logic signed [SQ_W-1:0]    p_shift;
    logic signed [EXT_W-1:0]   mag;
    logic signed [EXT_W-1:0]   sum_r;
    logic signed [EXT_W-1:0]   sum_i;

    logic                      mul_start;
    logic                      mul_done;
    data_t                     mul_a;
    data_t                     mul_b;
    logic signed [PROD_W-1:0]  mul_p;

    // True when v survives truncation to DATA_W signed bits
    function automatic logic fits(input logic signed [EXT_W-1:0] v);
        fits = (v == EXT_W'(data_t'(v)));
    endfunction

    mandel_mult u_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mul_start),
        .a     (mul_a),
        .b     (mul_b),
        .done  (mul_done),
        .p     (mul_p)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Multiplier issue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // The first product starts straight from the request, the next ones on
    // the done of the previous product
    always_comb begin
        mul_start = 1'b0;
        mul_a     = req_q.zr;
        mul_b     = req_q.zr;
        case (state)
            S_IDLE: begin
                mul_start = start;
                mul_a     = req.zr;
                mul_b     = req.zr;
            end
            S_RR: begin
                mul_start = mul_done;
                mul_a     = req_q.zi;
                mul_b     = req_q.zi;
            end
            S_II: begin
                mul_start = mul_done;
                mul_a     = req_q.zr;
                mul_b     = req_q.zi;
            end
            default: ;
        endcase
    end

    // Result arithmetic at full width
    always_comb begin
        p_shift = SQ_W'(mul_p >>> FRAC_W);
        mag     = EXT_W'(sq_rr) + EXT_W'(sq_ii);
        sum_r   = EXT_W'(sq_rr) - EXT_W'(sq_ii) + EXT_W'(req_q.cr);
        sum_i   = (EXT_W'(x_ri) <<< 1) + EXT_W'(req_q.ci);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: if (start) state <= S_RR;
                S_RR:   if (mul_done) state <= S_II;
                S_II:   if (mul_done) state <= S_RI;
                S_RI:   if (mul_done) state <= S_FIN;
                S_FIN: begin
                    state <= S_IDLE;
                    done  <= 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Operand latch, product capture and response
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            req_q <= req;
        end
        if (mul_done) begin
            case (state)
                S_RR:    sq_rr <= p_shift;
                S_II:    sq_ii <= p_shift;
                S_RI:    x_ri  <= p_shift;
                default: ;
            endcase
        end
        if (state == S_FIN) begin
            rsp.new_zr   <= data_t'(sum_r);
            rsp.new_zi   <= data_t'(sum_i);
            rsp.escaped  <= (mag > ESCAPE_LIM);      // Uses the old z
            rsp.overflow <= !fits(sum_r) || !fits(sum_i);
        end
    end

endmodule

//--- design/mandel_scan.sv
`timescale 1ns/1ps

module mandel_scan (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  mandel_pkg::mandel_cfg_t  cfg,
    output logic                     running,
    output logic                     finished,
    output logic                     alu_start,
    output mandel_pkg::alu_req_t     alu_req,
    input  logic                     alu_done,
    input  mandel_pkg::alu_rsp_t     alu_rsp,
    output logic                     pix_valid,
    output mandel_pkg::mandel_pix_t  pix
);
    import mandel_pkg::*;

    // S_FIN is the idle state between frames
    typedef enum logic [1:0] {S_FIN, S_ISSUE, S_WAIT, S_EMIT} state_t;

    state_t             state;
    data_t              cr;
    data_t              ci;
    data_t              zr;
    data_t              zi;
    logic [CTR_W-1:0]   ctr;
    logic               ovf;          // Overflow seen on the previous step
    logic [X_W-1:0]     x;
    logic [Y_W-1:0]     y;
    logic               frame_end;    // Pixel in S_EMIT is the last one of the frame

    data_t              step_inc;
    logic               brk;
    logic               last_col;
    logic               last_pix;

    // Shade from the final iteration count
    function automatic logic [3:0] shade_of(input logic [CTR_W-1:0] c,
                                            input logic [1:0]       sel);
        logic [3:0] msb;
        msb = '0;
        for (int i = 0; i < CTR_W; i++) begin
            if (c[i]) begin
                msb = 4'(i);          // Highest set bit wins
            end
        end
        case (sel)
            2'd0:    shade_of = c[3:0];
            2'd1:    shade_of = c[5:2];
            2'd2:    shade_of = c[7:4];
            default: shade_of = msb;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        step_inc = data_t'(cfg.step) + data_t'(1);
        brk      = alu_rsp.escaped || (ctr == cfg.max_ctr) || ovf;
        last_col = (x == X_W'(IMG_W - 1));
        last_pix = last_col && (y == Y_W'(IMG_H - 1));
    end

    assign running   = (state != S_FIN);
    assign finished  = (state == S_FIN);
    assign alu_start = (state == S_ISSUE);
    assign pix_valid = (state == S_EMIT);  // One cycle, then next pixel or idle

    assign alu_req = '{cr: cr, ci: ci, zr: zr, zi: zi};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame and pixel control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_FIN;
            ctr       <= '0;
            ovf       <= 1'b0;
            x         <= '0;
            y         <= '0;
            frame_end <= 1'b0;
        end else begin
            case (state)
                S_FIN: begin
                    if (run) begin                  // New frame from the origin
                        state     <= S_ISSUE;
                        ctr       <= '0;
                        ovf       <= 1'b0;
                        x         <= '0;
                        y         <= '0;
                        frame_end <= 1'b0;
                    end
                end
                S_ISSUE: state <= S_WAIT;
                S_WAIT: begin
                    if (alu_done) begin
                        if (brk) begin
                            state     <= S_EMIT;
                            ctr       <= '0;
                            ovf       <= 1'b0;
                            frame_end <= last_pix;
                            if (last_col) begin
                                x <= '0;
                                y <= y + 1'b1;
                            end else begin
                                x <= x + 1'b1;
                            end
                        end else begin
                            state <= S_ISSUE;       // Another iteration
                            ctr   <= ctr + 1'b1;
                            ovf   <= alu_rsp.overflow;
                        end
                    end
                end
                S_EMIT: state <= frame_end ? S_FIN : S_ISSUE;
                default: state <= S_FIN;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Point and pixel datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        case (state)
            S_FIN: begin
                if (run) begin
                    cr <= cfg.cr_offset;
                    ci <= cfg.ci_offset;
                    zr <= '0;
                    zi <= '0;
                end
            end
            S_WAIT: begin
                if (alu_done) begin
                    if (brk) begin
                        pix.x     <= x;
                        pix.y     <= y;
                        pix.shade <= shade_of(ctr, cfg.shade_sel);
                        zr        <= '0;
                        zi        <= '0;
                        if (last_col) begin          // Back to the row start
                            cr <= cfg.cr_offset;
                            ci <= ci + step_inc;
                        end else begin
                            cr <= cr + step_inc;
                        end
                    end else begin
                        zr <= alu_rsp.new_zr;
                        zi <= alu_rsp.new_zi;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

//--- design/mandel_top.sv
`timescale 1ns/1ps

module mandel_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  mandel_pkg::mandel_cfg_t  cfg,
    output logic                     running,
    output logic                     finished,
    output logic                     pix_valid,
    output mandel_pkg::mandel_pix_t  pix
);
    import mandel_pkg::*;

    // Scan controller to iteration unit
    logic      alu_start;
    alu_req_t  alu_req;
    logic      alu_done;
    alu_rsp_t  alu_rsp;

    mandel_scan u_scan (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .cfg       (cfg),
        .running   (running),
        .finished  (finished),
        .alu_start (alu_start),
        .alu_req   (alu_req),
        .alu_done  (alu_done),
        .alu_rsp   (alu_rsp),
        .pix_valid (pix_valid),
        .pix       (pix)
    );

    mandel_alu u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .start (alu_start),
        .req   (alu_req),
        .done  (alu_done),
        .rsp   (alu_rsp)
    );

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(negedge clk);     // Ten cycles in reset
        rst_n = 1'b1;
    end

endmodule

//--- bench/mandel_chk.sv
`timescale 1ns/1ps

module mandel_chk (
    input logic clk,
    input logic rst_n,
    input logic running,
    input logic finished,
    input logic pix_valid,
    input logic alu_start,
    input logic alu_done
);
    int   fail_cnt = 0;   // Read by the testbench
    logic alu_busy;       // Between an alu_start and its alu_done

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_busy <= 1'b0;
        end else if (alu_start) begin
            alu_busy <= 1'b1;
        end else if (alu_done) begin
            alu_busy <= 1'b0;
        end
    end

    a_pix_not_finished: assert property (@(posedge clk) disable iff (!rst_n)
        !(pix_valid && finished))
        else begin
            $error("pix_valid high while finished is high");
            fail_cnt++;
        end

    a_run_fin_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(running && finished))
        else begin
            $error("running and finished both high");
            fail_cnt++;
        end

    a_no_early_start: assert property (@(posedge clk) disable iff (!rst_n)
        alu_busy |-> !alu_start)
        else begin
            $error("alu_start issued before alu_done");
            fail_cnt++;
        end

    a_pix_single: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid |=> !pix_valid)
        else begin
            $error("pix_valid longer than one cycle");
            fail_cnt++;
        end

endmodule

bind mandel_scan mandel_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .running   (running),
    .finished  (finished),
    .pix_valid (pix_valid),
    .alu_start (alu_start),
    .alu_done  (alu_done)
);

//--- bench/mandel_tb.sv
`timescale 1ns/1ps

module mandel_tb;
    import mandel_pkg::*;

    localparam int PIX_TIMEOUT = 20000;   // Cycles, above the worst pixel latency

    logic        clk;
    logic        rst_n;
    logic        run;
    mandel_cfg_t cfg;
    logic        running;
    logic        finished;
    logic        pix_valid;
    mandel_pix_t pix;

    int errors;
    int checks;

    tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    mandel_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .cfg       (cfg),
        .running   (running),
        .finished  (finished),
        .pix_valid (pix_valid),
        .pix       (pix)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic int to_data(input int v);   // Wrap to DATA_W signed
        logic [DATA_W-1:0] t;
        t = v[DATA_W-1:0];
        to_data = t[DATA_W-1] ? int'(t) - (1 << DATA_W) : int'(t);
    endfunction

    function automatic bit fits_data(input int v);
        fits_data = (v >= -(1 << (DATA_W - 1))) && (v < (1 << (DATA_W - 1)));
    endfunction

    function automatic int shade_for(input int cnt, input logic [1:0] sel);
        int v;
        int msb;
        v   = cnt;
        msb = 0;
        while (v > 1) begin
            v = v >> 1;
            msb++;
        end
        case (sel)
            2'd0:    shade_for = cnt % 16;
            2'd1:    shade_for = (cnt / 4) % 16;
            2'd2:    shade_for = (cnt / 16) % 16;
            default: shade_for = msb;
        endcase
    endfunction

    function automatic mandel_pix_t expected_pixel(input mandel_cfg_t c, input int px,
                                                   input int py);
        int          inc;
        int          cr;
        int          ci;
        int          zr;
        int          zi;
        int          rr;
        int          ii;
        int          ri;
        int          nr;
        int          ni;
        int          cnt;
        bit          ovf;
        bit          nov;
        bit          stop;
        mandel_pix_t r;
        inc  = int'(c.step) + 1;
        cr   = to_data(int'(c.cr_offset) + px * inc);
        ci   = to_data(int'(c.ci_offset) + py * inc);
        zr   = 0;
        zi   = 0;
        cnt  = 0;
        ovf  = 1'b0;
        stop = 1'b0;
        while (!stop) begin
            rr  = (zr * zr) >>> FRAC_W;
            ii  = (zi * zi) >>> FRAC_W;
            ri  = (zr * zi) >>> FRAC_W;
            nr  = rr - ii + cr;
            ni  = 2 * ri + ci;
            nov = !fits_data(nr) || !fits_data(ni);
            if ((rr + ii) > ESCAPE_LIM || cnt == int'(c.max_ctr) || ovf) begin
                stop = 1'b1;
            end else begin
                zr  = to_data(nr);
                zi  = to_data(ni);
                cnt = cnt + 1;
                ovf = nov;
            end
        end
        r.x     = X_W'(px);
        r.y     = Y_W'(py);
        r.shade = 4'(shade_for(cnt, c.shade_sel));
        expected_pixel = r;
    endfunction

    function automatic mandel_cfg_t make_cfg(input int max_ctr, input int sel, input int step,
                                             input int cr_off, input int ci_off);
        mandel_cfg_t c;
        c.max_ctr   = CTR_W'(max_ctr);
        c.shade_sel = 2'(sel);
        c.step      = 7'(step);
        c.cr_offset = data_t'(cr_off);
        c.ci_offset = data_t'(ci_off);
        make_cfg = c;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and report
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t ns %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_and_finish();
        int asrt;
        asrt = DUT.u_scan.u_chk.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, asrt);
        if (errors == 0 && asrt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("Timeout while waiting for %s at %0t ns", what, $time);
        report_and_finish();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Waits and frame tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic wait_pixel();
        int  n;
        bit  seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < PIX_TIMEOUT) begin
            @(negedge clk);
            seen = pix_valid;
            n++;
        end
        if (!seen) abort_run("pix_valid");
    endtask

    task automatic wait_finished();
        int n;
        n = 0;
        while (!finished && n < PIX_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!finished) abort_run("finished");
    endtask

    task automatic start_frame(input mandel_cfg_t c);
        wait_finished();
        @(negedge clk);
        cfg = c;
        run = 1'b1;
        @(negedge clk);
        run = 1'b0;
        check_value("running", running, 1);
        check_value("finished", finished, 0);
    endtask

    task automatic compare_frame(input mandel_cfg_t c);
        mandel_pix_t exp;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                wait_pixel();
                exp = expected_pixel(c, x, y);
                check_value("pix.x", pix.x, exp.x);
                check_value("pix.y", pix.y, exp.y);
                check_value("pix.shade", pix.shade, exp.shade);
            end
        end
        @(negedge clk);                  // One cycle after the last pixel
        check_value("finished", finished, 1);
        check_value("running", running, 0);
    endtask

    task automatic run_frame(input mandel_cfg_t c);
        start_frame(c);
        compare_frame(c);
    endtask

    task automatic pulse_run_mid_frame();
        repeat (500) @(negedge clk);
        check_value("running", running, 1);   // Strobe lands inside the frame
        run = 1'b1;
        @(negedge clk);
        run = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        mandel_cfg_t c;
        int          n;
        errors = 0;
        checks = 0;
        run    = 1'b0;
        cfg    = '0;
        void'($urandom(32'he108));

        n = 0;
        while (rst_n !== 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) abort_run("reset release");

        repeat (20) begin                          // Idle after reset
            @(negedge clk);
            check_value("finished", finished, 1);
            check_value("running", running, 0);
            check_value("pix_valid", pix_valid, 0);
        end

        run_frame(make_cfg(30, 0, 31, -512, -192));
        run_frame(make_cfg(255, 1, 31, -512, 64));
        run_frame(make_cfg(255, 2, 15, -384, -96));
        run_frame(make_cfg(255, 3, 31, -512, -384));
        run_frame(make_cfg(0, 3, 31, -512, -192));    // Count 0 everywhere

        // c far outside, wrapping offsets and overflowing steps
        run_frame(make_cfg(255, 0, 127, 1536, 1280));
        run_frame(make_cfg(255, 3, 100, -2048, -2048));

        c = make_cfg(30, 0, 31, -512, -192);
        start_frame(c);
        fork
            compare_frame(c);
            pulse_run_mid_frame();
        join

        repeat (3) begin
            c.max_ctr   = CTR_W'($urandom % 64);
            c.shade_sel = 2'($urandom);
            c.step      = 7'($urandom);
            c.cr_offset = data_t'($urandom);
            c.ci_offset = data_t'($urandom);
            run_frame(c);
        end

        report_and_finish();
    end

endmodule

//--- compile.f
design/mandel_pkg.sv
design/mandel_mult.sv
design/mandel_alu.sv
design/mandel_scan.sv
design/mandel_top.sv
bench/tb_clk_gen.sv
bench/mandel_chk.sv
bench/mandel_tb.sv
